// File: all.f
logic/cpuPkg.sv
logic/issueBus.sv
logic/fetchUnit.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/cpuCore.sv
verif/instMemory.sv
verif/cpuTb.sv

// File: Bender.yml
package:
  name: cpucore

sources:
  - logic/cpuPkg.sv
  - logic/issueBus.sv
  - logic/fetchUnit.sv
  - logic/registerFile.sv
  - logic/decodeStage.sv
  - logic/executeStage.sv
  - logic/cpuCore.sv
  - target: test
    files:
      - verif/instMemory.sv
      - verif/cpuTb.sv

// File: verif/cpuTb.sv
// Runs the program in instMemory against a reference model; resetPc 1000 hex, seed 374 hex
module cpuTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam cpuPkg::word resetPc = 32'h0000_1000;
  localparam int progLen = 20;
  // Per-instruction budget scaled by the longest ack delay
  localparam int watchdogCycles = progLen * 200 * 6;
  localparam int drainCycles = 60;

  logic clk;
  logic rst;
  logic instReq;
  cpuPkg::word instAddr;
  logic instAck;
  cpuPkg::word instData;
  logic wbValid;
  cpuPkg::regIdx wbDst;
  cpuPkg::word wbData;

  // Predicted writebacks, oldest first
  cpuPkg::regIdx expDst [$];
  cpuPkg::word expData [$];
  cpuPkg::regIdx dstWant;
  cpuPkg::word dataWant;
  int expected;
  int retired;
  int resetErrors;
  int wbErrors;
  int hsErrors;
  int drainStart;
  int testCount;
  int failedTests;
  // Previous negedge sample
  logic prevReq;
  logic prevAck;
  cpuPkg::word prevAddr;

  cpuCore #(
    .resetPc (resetPc)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .instReq  (instReq),
    .instAddr (instAddr),
    .instAck  (instAck),
    .instData (instData),
    .wbValid  (wbValid),
    .wbDst    (wbDst),
    .wbData   (wbData)
  );

  instMemory #(
    .progLen (progLen),
    .base    (resetPc),
    .seed    (32'h374)
  ) iMem (
    .clk      (clk),
    .rst      (rst),
    .instReq  (instReq),
    .instAddr (instAddr),
    .instAck  (instAck),
    .instData (instData)
  );

  always #20 clk = ~clk;

  task automatic valueError(input string name, input cpuPkg::word want, input cpuPkg::word got,
                            inout int count);
    $display("ERROR %s expected %h got %h", name, want, got);
    count++;
  endtask

  task automatic plainError(input string msg, inout int count);
    $display("%s", msg);
    count++;
  endtask

  task automatic finishTest(input string name, input int errors);
    testCount++;
    if (errors == 0)
      $display("test %s: passed", name);
    else
    begin
      $display("test %s: failed with %0d errors", name, errors);
      failedTests++;
    end
  endtask

  // ISA interpreter over the memory image, fills the expected queues
  task automatic predict();
    cpuPkg::word regs [cpuPkg::numRegs];
    cpuPkg::word pc;
    cpuPkg::word next;
    cpuPkg::word w;
    cpuPkg::word imm;
    cpuPkg::word result;
    logic [6:0] op;
    int steps;
    for (int i = 0; i < cpuPkg::numRegs; i++)
      regs[i] = '0;
    pc = resetPc;
    steps = 0;
    while (pc >= resetPc && pc < resetPc + 4 * progLen && steps < 4 * progLen)
    begin
      w = iMem.prog[(pc - resetPc) >> 2];
      op = w[31:25];
      imm = {{17{w[14]}}, w[14:0]};
      next = pc + 4;
      // Fields: dst 24:20, src1 19:15, src2 14:10
      case (op)
        cpuPkg::opAdd: result = regs[w[19:15]] + regs[w[14:10]];
        cpuPkg::opSub: result = regs[w[19:15]] - regs[w[14:10]];
        cpuPkg::opMovi: result = imm;
        cpuPkg::opBeq: next = (regs[w[19:15]] == regs[w[24:20]]) ? pc + imm : next;
        cpuPkg::opJump: next = regs[w[19:15]] + imm;
        default: result = '0;
      endcase
      if (op == cpuPkg::opAdd || op == cpuPkg::opSub || op == cpuPkg::opMovi)
      begin
        regs[w[24:20]] = result;
        expDst.push_back(w[24:20]);
        expData.push_back(result);
      end
      pc = next;
      steps++;
    end
  endtask

  // Writeback order and values
  always @(negedge clk)
  begin
    if (wbValid === 1'b1)
    begin
      assert (expData.size() > 0)
      else plainError("writeback arrived after the whole program had retired", wbErrors);
      if (expData.size() > 0)
      begin
        dstWant = expDst.pop_front();
        dataWant = expData.pop_front();
        retired++;
        assert (wbDst == dstWant) else valueError("wbDst", dstWant, wbDst, wbErrors);
        assert (wbData == dataWant) else valueError("wbData", dataWant, wbData, wbErrors);
      end
    end
  end

  // Fetch protocol rules
  always @(negedge clk)
  begin
    assert (!(instReq === 1'b1 && prevReq === 1'b0 && prevAck === 1'b1))
    else plainError("instReq rose while instAck was still high", hsErrors);
    assert (!(instReq === 1'b1 && prevReq === 1'b1) || instAddr == prevAddr)
    else valueError("instAddr", prevAddr, instAddr, hsErrors);
    prevReq = instReq;
    prevAck = instAck;
    prevAddr = instAddr;
  end

  initial
  begin
    repeat (watchdogCycles)
      @(posedge clk);
    $display("watchdog expired before the program finished");
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    retired = 0;
    resetErrors = 0;
    wbErrors = 0;
    hsErrors = 0;
    testCount = 0;
    failedTests = 0;
    // Sixteenth edge follows the loop
    repeat (15)
    begin
      @(negedge clk);
      assert (instReq === 1'b0 && wbValid === 1'b0)
      else plainError("instReq or wbValid was not low during reset", resetErrors);
    end
    @(posedge clk);
    #2;
    rst = 1'b0;
    predict();
    expected = expData.size();
    while (instReq !== 1'b1)
      @(negedge clk);
    assert (instAddr == resetPc) else valueError("instAddr", resetPc, instAddr, resetErrors);
    finishTest("reset", resetErrors);

    // Arithmetic, bypass and branches through the writeback stream
    while (retired < expected)
      @(negedge clk);
    finishTest("program", wbErrors);

    // Only NOPs remain, nothing may write back
    drainStart = wbErrors;
    repeat (drainCycles)
      @(negedge clk);
    finishTest("drain", wbErrors - drainStart);
    finishTest("handshake", hsErrors);

    $display("tests %0d, failed %0d, errors %0d", testCount, failedTests,
             resetErrors + wbErrors + hsErrors);
    if (resetErrors + wbErrors + hsErrors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: verif/instMemory.sv
// Four-phase fetch responder holding a fixed 20-word program; words outside it read as NOPs
module instMemory #(
  parameter int progLen = 20,
  parameter cpuPkg::word base = 32'h0000_1000,
  parameter int unsigned seed = 32'h374
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        instReq,
  input  cpuPkg::word instAddr,
  output logic        instAck,
  output cpuPkg::word instData
);
  timeunit 1ns;
  timeprecision 100ps;

  // Program image, one word per instruction
  cpuPkg::word prog [progLen];
  int unsigned delay;
  int unsigned seedVal;

  function automatic cpuPkg::word regOp(cpuPkg::opcode op, int dst, int src1, int src2);
    return {op, 5'(dst), 5'(src1), 5'(src2), 10'b0};
  endfunction

  function automatic cpuPkg::word immOp(cpuPkg::opcode op, int dst, int src1, int imm);
    return {op, 5'(dst), 5'(src1), 15'(imm)};
  endfunction

  // Outside the program, NOP opcode with the whole address folded into the low bits
  function automatic cpuPkg::word wordAt(cpuPkg::word addr);
    cpuPkg::word offset;
    offset = addr - base;
    if (offset[1:0] == 2'b00 && offset < 4 * progLen)
      return prog[offset >> 2];
    return {cpuPkg::opNop, 25'(addr ^ (addr >> 25))};
  endfunction

  initial
  begin
    prog[0] = immOp(cpuPkg::opMovi, 1, 0, 5);
    prog[1] = immOp(cpuPkg::opMovi, 2, 0, -3);
    // Dependent on the previous two results
    prog[2] = regOp(cpuPkg::opAdd, 3, 1, 2);
    prog[3] = regOp(cpuPkg::opSub, 4, 3, 1);
    prog[4] = regOp(cpuPkg::opAdd, 5, 4, 3);
    // r2 equals r4, taken to 1020
    prog[5] = immOp(cpuPkg::opBeq, 4, 2, 12);
    prog[6] = immOp(cpuPkg::opMovi, 6, 0, 'h111);
    prog[7] = immOp(cpuPkg::opMovi, 7, 0, 'h222);
    // r3 differs from r1, falls through
    prog[8] = immOp(cpuPkg::opBeq, 1, 3, 8);
    prog[9] = immOp(cpuPkg::opMovi, 8, 0, 100);
    // Unknown opcode, then a plain NOP
    prog[10] = 32'h5a5a_5a5a;
    prog[11] = cpuPkg::nopWord;
    prog[12] = immOp(cpuPkg::opMovi, 9, 0, 'h1040);
    // Register relative, lands on 1044
    prog[13] = immOp(cpuPkg::opJump, 0, 9, 4);
    prog[14] = regOp(cpuPkg::opAdd, 10, 1, 1);
    prog[15] = immOp(cpuPkg::opMovi, 11, 0, 7);
    prog[16] = regOp(cpuPkg::opSub, 12, 1, 1);
    prog[17] = regOp(cpuPkg::opSub, 13, 5, 8);
    prog[18] = regOp(cpuPkg::opAdd, 14, 13, 13);
    prog[19] = regOp(cpuPkg::opAdd, 1, 1, 14);
  end

  // Everything sampled and driven 2 ns after the rising edge
  initial
  begin
    instAck = 1'b0;
    instData = '0;
    seedVal = seed;
    void'($urandom(seedVal));
    forever
    begin
      @(posedge clk);
      #2;
      if (!rst && instReq)
      begin
        // Zero to five idle cycles before the ack
        delay = $urandom_range(5, 0);
        repeat (delay)
        begin
          @(posedge clk);
          #2;
        end
        instData = wordAt(instAddr);
        instAck = 1'b1;
        // Hold the word until the request drops
        do
        begin
          @(posedge clk);
          #2;
        end
        while (instReq);
        // Slow release, zero to two more cycles with ack still high
        delay = $urandom_range(2, 0);
        repeat (delay)
        begin
          @(posedge clk);
          #2;
        end
        instAck = 1'b0;
      end
    end
  end

endmodule

// File: logic/cpuCore.sv
// Four-stage core with external fetch only; writeback port shows every register write in order
module cpuCore #(
  parameter cpuPkg::word resetPc = 32'h0000_1000
) (
  input  logic          clk,
  input  logic          rst,
  output logic          instReq,
  output cpuPkg::word   instAddr,
  input  logic          instAck,
  input  cpuPkg::word   instData,
  output logic          wbValid,
  output cpuPkg::regIdx wbDst,
  output cpuPkg::word   wbData
);

  // Fetch to decode
  logic fetchValid;
  cpuPkg::instWord fetchInst;
  cpuPkg::word fetchPc;

  // Taken branch from execute
  logic redirectValid;
  cpuPkg::word redirectPc;

  // Execute result for bypass
  logic exValid;
  cpuPkg::regIdx exDst;
  cpuPkg::word exData;

  // Register file reads
  cpuPkg::regIdx rdAddrA;
  cpuPkg::regIdx rdAddrB;
  cpuPkg::word rdDataA;
  cpuPkg::word rdDataB;

  issueBus issue ();

  fetchUnit #(
    .resetPc (resetPc)
  ) iFetch (
    .clk           (clk),
    .rst           (rst),
    .instReq       (instReq),
    .instAddr      (instAddr),
    .instAck       (instAck),
    .instData      (instData),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .fetchValid    (fetchValid),
    .fetchInst     (fetchInst),
    .fetchPc       (fetchPc)
  );

  // Written straight from the writeback register
  registerFile iRegs (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wbValid),
    .wrAddr  (wbDst),
    .wrData  (wbData)
  );

  decodeStage iDecode (
    .fetchValid    (fetchValid),
    .fetchInst     (fetchInst),
    .fetchPc       (fetchPc),
    .redirectValid (redirectValid),
    .exValid       (exValid),
    .exDst         (exDst),
    .exData        (exData),
    .wbValid       (wbValid),
    .wbDst         (wbDst),
    .wbData        (wbData),
    .rdAddrA       (rdAddrA),
    .rdAddrB       (rdAddrB),
    .rdDataA       (rdDataA),
    .rdDataB       (rdDataB),
    .issue         (issue)
  );

  executeStage iExecute (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .exValid       (exValid),
    .exDst         (exDst),
    .exData        (exData),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .wbValid       (wbValid),
    .wbDst         (wbDst),
    .wbData        (wbData)
  );

endmodule

// File: logic/executeStage.sv
// Single-cycle ALU; branches resolve here, so redirect and forward outputs are combinational
module executeStage (
  input  logic          clk,
  input  logic          rst,
  issueBus.sink         issue,
  output logic          exValid,
  output cpuPkg::regIdx exDst,
  output cpuPkg::word   exData,
  output logic          redirectValid,
  output cpuPkg::word   redirectPc,
  output logic          wbValid,
  output cpuPkg::regIdx wbDst,
  output cpuPkg::word   wbData
);

  // Execute register
  logic xValid;
  cpuPkg::opcode xOp;
  cpuPkg::regIdx xDst;
  cpuPkg::word xOpA;
  cpuPkg::word xOpB;
  cpuPkg::word xPc;
  cpuPkg::word xImm;

  logic writes;
  logic taken;

  // Accept one item per cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      xValid <= 1'b0;
    else
      xValid <= issue.valid;
    xOp <= issue.op;
    xDst <= issue.dst;
    xOpA <= issue.opA;
    xOpB <= issue.opB;
    xPc <= issue.pc;
    xImm <= issue.imm;
  end

  // ALU and branch resolution
  always_comb
  begin
    exData = xImm;
    writes = 1'b0;
    taken = 1'b0;
    // JUMP target, register relative
    redirectPc = xOpA + xImm;
    case (xOp)
      cpuPkg::opAdd:
      begin
        exData = xOpA + xOpB;
        writes = 1'b1;
      end
      cpuPkg::opSub:
      begin
        exData = xOpA - xOpB;
        writes = 1'b1;
      end
      // Result is the immediate itself
      cpuPkg::opMovi:
        writes = 1'b1;
      cpuPkg::opBeq:
      begin
        taken = (xOpA == xOpB);
        // PC relative
        redirectPc = xPc + xImm;
      end
      cpuPkg::opJump:
        taken = 1'b1;
      default:
        writes = 1'b0;
    endcase
  end

  // Forward path to decode bypass
  assign exValid = xValid && writes;
  assign exDst = xDst;
  assign redirectValid = xValid && taken;

  // Writeback register, drives the register file next edge
  always_ff @(posedge clk)
  begin
    if (rst)
      wbValid <= 1'b0;
    else
      wbValid <= exValid;
    wbDst <= exDst;
    wbData <= exData;
  end

endmodule

// File: logic/decodeStage.sv
// Combinational decode that never stalls; bypass assumes results exist only in execute and writeback
module decodeStage (
  input  logic            fetchValid,
  input  cpuPkg::instWord fetchInst,
  input  cpuPkg::word     fetchPc,
  input  logic            redirectValid,
  input  logic            exValid,
  input  cpuPkg::regIdx   exDst,
  input  cpuPkg::word     exData,
  input  logic            wbValid,
  input  cpuPkg::regIdx   wbDst,
  input  cpuPkg::word     wbData,
  output cpuPkg::regIdx   rdAddrA,
  output cpuPkg::regIdx   rdAddrB,
  input  cpuPkg::word     rdDataA,
  input  cpuPkg::word     rdDataB,
  issueBus.source         issue
);

  cpuPkg::opcode op;
  logic known;
  logic signed [cpuPkg::immBits-1:0] immField;

  // Youngest producer first, then writeback, then the register file
  function automatic cpuPkg::word bypass(
    input cpuPkg::regIdx idx,
    input cpuPkg::word   rfData
  );
    if (exValid && exDst == idx)
      return exData;
    if (wbValid && wbDst == idx)
      return wbData;
    return rfData;
  endfunction

  // Opcode sits at the same place in both formats
  assign op = fetchInst.regView.op;
  assign immField = fetchInst.immView.imm;

  // NOP and unknown opcodes become bubbles
  always_comb
  begin
    case (op)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opMovi, cpuPkg::opBeq, cpuPkg::opJump:
        known = 1'b1;
      default:
        known = 1'b0;
    endcase
  end

  // Port A always src1
  assign rdAddrA = fetchInst.regView.src1;
  // BEQ compares against its dst field
  assign rdAddrB = (op == cpuPkg::opBeq) ? fetchInst.immView.dst : fetchInst.regView.src2;

  // Squash when the branch in execute is taken
  assign issue.valid = fetchValid && known && !redirectValid;
  assign issue.op = op;
  assign issue.dst = fetchInst.regView.dst;
  assign issue.opA = bypass(rdAddrA, rdDataA);
  assign issue.opB = bypass(rdAddrB, rdDataB);
  assign issue.pc = fetchPc;

  // Sign extension
  assign issue.imm = {{(cpuPkg::xlen - cpuPkg::immBits){immField[cpuPkg::immBits-1]}}, immField};

endmodule

// File: logic/registerFile.sv
// No hardwired zero register; a read of the register written on the same edge returns the old value
module registerFile (
  input  logic          clk,
  input  logic          rst,
  input  cpuPkg::regIdx rdAddrA,
  input  cpuPkg::regIdx rdAddrB,
  output cpuPkg::word   rdDataA,
  output cpuPkg::word   rdDataB,
  input  logic          wrEn,
  input  cpuPkg::regIdx wrAddr,
  input  cpuPkg::word   wrData
);

  // Architectural registers
  cpuPkg::word regs [cpuPkg::numRegs];

  // Single write port, fed from writeback
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // All registers start at zero
      for (int i = 0; i < cpuPkg::numRegs; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
    begin
      regs[wrAddr] <= wrData;
    end
  end

  // Asynchronous reads for decode
  // Same-cycle writes are covered by the writeback bypass
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

endmodule

// File: logic/fetchUnit.sv
// One outstanding four-phase fetch at a time, no prefetch; memory must hold instData while instAck
module fetchUnit #(
  parameter cpuPkg::word resetPc = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            rst,
  output logic            instReq,
  output cpuPkg::word     instAddr,
  input  logic            instAck,
  input  cpuPkg::word     instData,
  input  logic            redirectValid,
  input  cpuPkg::word     redirectPc,
  output logic            fetchValid,
  output cpuPkg::instWord fetchInst,
  output cpuPkg::word     fetchPc
);

  // Handshake phase
  typedef enum logic {
    waitAck,
    waitRelease
  } fetchState;

  fetchState state;
  // Address of the next request to launch
  cpuPkg::word pc;
  // Outstanding word belongs to a squashed path
  logic discard;
  logic capture;

  // Ack seen while request is still up
  assign capture = (state == waitAck) && instAck;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= waitRelease;
      instReq <= 1'b0;
      instAddr <= resetPc;
      pc <= resetPc;
      discard <= 1'b0;
    end
    else
    begin
      case (state)
        waitAck:
        begin
          // Phase 3, drop request once the word is taken
          if (instAck)
          begin
            instReq <= 1'b0;
            state <= waitRelease;
          end
        end
        default:
        begin
          // Launch only after memory released ack
          // Address then stays frozen until capture
          if (!instAck)
          begin
            instReq <= 1'b1;
            instAddr <= redirectValid ? redirectPc : pc;
            state <= waitAck;
          end
        end
      endcase

      // Taken branch beats sequential advance
      if (redirectValid)
        pc <= redirectPc;
      else if (capture && !discard)
        pc <= pc + 32'd4;

      // Let the stale transfer finish, then throw it away
      if (capture)
        discard <= 1'b0;
      else if (redirectValid && state == waitAck)
        discard <= 1'b1;
    end
  end

  // Decode input register
  // Bubble unless a live word arrives this cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fetchValid <= 1'b0;
      fetchInst <= cpuPkg::nopWord;
    end
    else if (capture && !discard && !redirectValid)
    begin
      fetchValid <= 1'b1;
      fetchInst <= instData;
      fetchPc <= instAddr;
    end
    else
    begin
      fetchValid <= 1'b0;
      fetchInst <= cpuPkg::nopWord;
    end
  end

endmodule

// File: logic/issueBus.sv
// Decode to execute link with no handshake; execute takes one item on every cycle
interface issueBus;

  // Low for bubbles, squashed and unknown instructions
  logic valid;
  cpuPkg::opcode op;
  cpuPkg::regIdx dst;

  // Operands already bypassed
  cpuPkg::word opA;
  cpuPkg::word opB;

  // PC of the instruction, BEQ target base
  cpuPkg::word pc;

  // Sign-extended immediate field
  cpuPkg::word imm;

  // Decode side
  modport source (
    output valid,
    output op,
    output dst,
    output opA,
    output opB,
    output pc,
    output imm
  );

  // Execute side
  modport sink (
    input valid,
    input op,
    input dst,
    input opA,
    input opB,
    input pc,
    input imm
  );

endinterface

// File: logic/cpuPkg.sv
// Integer-only ISA with 32 registers and 15-bit signed immediates; no loads, stores or exceptions
package cpuPkg;

  // Data path and register file geometry
  localparam int xlen = 32;
  localparam int regIdxBits = 5;
  localparam int numRegs = 32;

  // Instruction field widths
  localparam int opcodeBits = 7;
  localparam int immBits = 15;

  // Data value or byte address
  typedef logic [xlen-1:0] word;

  typedef logic [regIdxBits-1:0] regIdx;

  // Supported opcodes
  // Any other pattern decodes as a bubble
  typedef enum logic [opcodeBits-1:0] {
    opAdd  = 7'h00,
    opSub  = 7'h01,
    opMovi = 7'h15,
    opBeq  = 7'h30,
    opJump = 7'h31,
    opNop  = 7'h7f
  } opcode;

  // Register format, used by ADD and SUB
  typedef struct packed {
    opcode op;
    regIdx dst;
    regIdx src1;
    regIdx src2;
    // Ignored by the core
    logic [xlen-opcodeBits-3*regIdxBits-1:0] spare;
  } regFormat;

  // Immediate format, used by MOVI, BEQ and JUMP
  typedef struct packed {
    opcode op;
    // BEQ compares src1 against this register
    regIdx dst;
    regIdx src1;
    logic signed [immBits-1:0] imm;
  } immFormat;

  // Same 32 bits, two views
  // Opcode, dst and src1 sit at the same place in both
  typedef union packed {
    regFormat regView;
    immFormat immView;
  } instWord;

  // All ones, opcode field reads as NOP
  localparam instWord nopWord = '1;

endpackage
